//--- logic/video_pkg.sv
`default_nettype none

// Pixel format and raster geometry shared by the whole video path
package video_pkg;

    // RGB565 colour channels
    typedef logic [4:0] r_chan_t;
    typedef logic [5:0] g_chan_t;
    typedef logic [4:0] b_chan_t;

    // One RGB565 pixel, red in the top bits
    typedef logic [15:0] pixel_t;

    // Unsigned screen coordinate
    typedef logic [10:0] coord_t;

    // Signed coordinate in foreground space, also used for offsets
    typedef logic signed [11:0] scoord_t;

    // Visible raster
    localparam int RES_X = 800;
    localparam int RES_Y = 600;

    // Stored foreground image
    localparam int FG_WIDTH  = 256;
    localparam int FG_HEIGHT = 128;

endpackage

`default_nettype wire

//--- logic/overlay_cfg_pkg.sv
`default_nettype none

// Overlay settings as seen by the host, plus pipeline timing
package overlay_cfg_pkg;

    typedef enum logic [1:0] {
        MODE_BG        = 2'd0, // Background only
        MODE_KEY       = 2'd1, // Chroma key
        MODE_BLEND     = 2'd2, // Opacity blend
        MODE_KEY_BLEND = 2'd3  // Blend where foreground is not key colour
    } overlay_mode_t;

    typedef logic [1:0]  fg_scale_t;  // Magnification is 2**scale
    typedef logic [3:0]  opacity_t;   // Eighths, 0 to 8
    typedef logic [3:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // Host register map
    localparam cfg_addr_t REG_MODE        = 4'd0;
    localparam cfg_addr_t REG_SCALE       = 4'd1;
    localparam cfg_addr_t REG_OFFSET_X    = 4'd2;
    localparam cfg_addr_t REG_OFFSET_Y    = 4'd3;
    localparam cfg_addr_t REG_OPACITY     = 4'd4;
    localparam cfg_addr_t REG_CLIP_LEFT   = 4'd5;
    localparam cfg_addr_t REG_CLIP_RIGHT  = 4'd6;
    localparam cfg_addr_t REG_CLIP_TOP    = 4'd7;
    localparam cfg_addr_t REG_CLIP_BOTTOM = 4'd8;
    localparam cfg_addr_t REG_KEY_COLOR   = 4'd9;

    // Pipeline timing, counted in edges from the pixel input
    localparam int ADDR_LATENCY  = 1;
    localparam int FETCH_LATENCY = 3;
    localparam int OUT_LATENCY   = 4;

    localparam int OPACITY_SHIFT = 3;
    localparam opacity_t OPACITY_FULL = opacity_t'(1 << OPACITY_SHIFT);

endpackage

`default_nettype wire

//--- logic/overlay_cfg_port.sv
`default_nettype none

module overlay_cfg_port (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               cfg_req,
    input  wire overlay_cfg_pkg::cfg_addr_t   cfg_addr,
    input  wire overlay_cfg_pkg::cfg_data_t   cfg_data,
    output logic                              cfg_ack,
    output overlay_cfg_pkg::overlay_mode_t    mode,
    output overlay_cfg_pkg::fg_scale_t        scale,
    output video_pkg::scoord_t                offset_x,
    output video_pkg::scoord_t                offset_y,
    output overlay_cfg_pkg::opacity_t         opacity,
    output video_pkg::coord_t                 clip_left,
    output video_pkg::coord_t                 clip_right,
    output video_pkg::coord_t                 clip_top,
    output video_pkg::coord_t                 clip_bottom,
    output video_pkg::pixel_t                 key_color
);
    typedef enum logic {
        IDLE,
        ACKED
    } port_state_t;

    port_state_t state;
    logic        wr_en;

    // One write per request, taken on the first cycle req is seen
    assign wr_en   = (state == IDLE) && cfg_req;
    assign cfg_ack = (state == ACKED);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:    if (cfg_req) state <= ACKED;
                ACKED:   if (!cfg_req) state <= IDLE;  // Wait for host to drop req
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mode        <= overlay_cfg_pkg::MODE_BG;
            scale       <= '0;
            offset_x    <= '0;
            offset_y    <= '0;
            opacity     <= overlay_cfg_pkg::OPACITY_FULL;
            clip_left   <= '0;
            clip_right  <= video_pkg::coord_t'(video_pkg::RES_X);  // Full raster
            clip_top    <= '0;
            clip_bottom <= video_pkg::coord_t'(video_pkg::RES_Y);
            key_color   <= '0;
        end
        else if (wr_en)
        begin
            case (cfg_addr)
                overlay_cfg_pkg::REG_MODE:     mode <= overlay_cfg_pkg::overlay_mode_t'(cfg_data[1:0]);
                overlay_cfg_pkg::REG_SCALE:    scale <= cfg_data[1:0];
                overlay_cfg_pkg::REG_OFFSET_X: offset_x <= cfg_data[11:0];
                overlay_cfg_pkg::REG_OFFSET_Y: offset_y <= cfg_data[11:0];
                overlay_cfg_pkg::REG_OPACITY:
                begin
                    // Saturate so the blend never sees more than full opacity
                    if (cfg_data > overlay_cfg_pkg::cfg_data_t'(overlay_cfg_pkg::OPACITY_FULL))
                        opacity <= overlay_cfg_pkg::OPACITY_FULL;
                    else
                        opacity <= cfg_data[3:0];
                end
                overlay_cfg_pkg::REG_CLIP_LEFT:   clip_left <= cfg_data[10:0];
                overlay_cfg_pkg::REG_CLIP_RIGHT:  clip_right <= cfg_data[10:0];
                overlay_cfg_pkg::REG_CLIP_TOP:    clip_top <= cfg_data[10:0];
                overlay_cfg_pkg::REG_CLIP_BOTTOM: clip_bottom <= cfg_data[10:0];
                overlay_cfg_pkg::REG_KEY_COLOR:   key_color <= cfg_data;
                default: ;  // Unknown index, acked and dropped
            endcase
        end
    end

    // Ack may only rise in answer to a pending request
    ack_follows_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(cfg_ack) |-> $past(cfg_req)
    );

endmodule

`default_nettype wire

//--- logic/fg_addr_gen.sv
`default_nettype none

module fg_addr_gen (
    input  wire                          clk,
    input  wire                          rst,
    input  wire video_pkg::coord_t       pixel_x,
    input  wire video_pkg::coord_t       pixel_y,
    input  wire                          output_enable,
    input  wire overlay_cfg_pkg::fg_scale_t scale,
    input  wire video_pkg::scoord_t      offset_x,
    input  wire video_pkg::scoord_t      offset_y,
    input  wire video_pkg::coord_t       clip_left,
    input  wire video_pkg::coord_t       clip_right,
    input  wire video_pkg::coord_t       clip_top,
    input  wire video_pkg::coord_t       clip_bottom,
    output video_pkg::scoord_t           fg_req_x,
    output video_pkg::scoord_t           fg_req_y,
    output logic                         fg_req_active
);
    video_pkg::scoord_t rel_x;
    video_pkg::scoord_t rel_y;
    video_pkg::scoord_t fg_x;
    video_pkg::scoord_t fg_y;
    logic               in_image;
    logic               in_clip;

    // Screen position relative to the foreground origin
    assign rel_x = video_pkg::scoord_t'({1'b0, pixel_x}) - offset_x;
    assign rel_y = video_pkg::scoord_t'({1'b0, pixel_y}) - offset_y;

    // Magnification, keeps the sign for pixels left of or above the image
    assign fg_x = rel_x >>> scale;
    assign fg_y = rel_y >>> scale;

    assign in_image = !fg_x[11] && (fg_x < video_pkg::scoord_t'(video_pkg::FG_WIDTH))
                   && !fg_y[11] && (fg_y < video_pkg::scoord_t'(video_pkg::FG_HEIGHT));

    // Clip window is half open on the right and bottom
    assign in_clip = (pixel_x >= clip_left) && (pixel_x < clip_right)
                  && (pixel_y >= clip_top) && (pixel_y < clip_bottom);

    always_ff @(posedge clk)
    begin
        if (rst)
            fg_req_active <= 1'b0;
        else
            fg_req_active <= output_enable && in_image && in_clip;
    end

    always_ff @(posedge clk)
    begin
        fg_req_x <= fg_x;
        fg_req_y <= fg_y;
    end

    // Memory is never asked for a location outside the stored image
    req_inside_image: assert property (
        @(posedge clk) disable iff (rst)
        fg_req_active |->
            !fg_req_x[11] && (fg_req_x < video_pkg::scoord_t'(video_pkg::FG_WIDTH))
            && !fg_req_y[11] && (fg_req_y < video_pkg::scoord_t'(video_pkg::FG_HEIGHT))
    );

endmodule

`default_nettype wire

//--- logic/pixel_compositor.sv
`default_nettype none

module pixel_compositor (
    input  wire                              clk,
    input  wire                              rst,
    input  wire video_pkg::pixel_t           bg_pixel,
    input  wire video_pkg::pixel_t           fg_pixel,
    input  wire                              fg_skip,
    input  wire video_pkg::coord_t           pixel_x,
    input  wire video_pkg::coord_t           pixel_y,
    input  wire                              output_enable,
    input  wire overlay_cfg_pkg::overlay_mode_t mode,
    input  wire overlay_cfg_pkg::opacity_t   opacity,
    input  wire video_pkg::pixel_t           key_color,
    output video_pkg::pixel_t                pixel_out,
    output video_pkg::coord_t                pixel_x_out,
    output video_pkg::coord_t                pixel_y_out
);
    // Per-channel weighted mix, sized for the widest (green) channel
    function automatic video_pkg::g_chan_t blend_chan(
        input video_pkg::g_chan_t        fg,
        input video_pkg::g_chan_t        bg,
        input overlay_cfg_pkg::opacity_t op
    );
        logic [9:0] sum;
        sum = fg * op + bg * (overlay_cfg_pkg::OPACITY_FULL - op);
        return video_pkg::g_chan_t'(sum >> overlay_cfg_pkg::OPACITY_SHIFT);
    endfunction

    video_pkg::r_chan_t fg_r, bg_r, mix_r;
    video_pkg::g_chan_t fg_g, bg_g, mix_g;
    video_pkg::b_chan_t fg_b, bg_b, mix_b;
    video_pkg::g_chan_t mix_r_wide;
    video_pkg::g_chan_t mix_b_wide;

    logic              fg_visible;
    video_pkg::pixel_t keyed;
    video_pkg::pixel_t blended;
    video_pkg::pixel_t mixed;

    assign {fg_r, fg_g, fg_b} = fg_pixel;
    assign {bg_r, bg_g, bg_b} = bg_pixel;

    // Foreground shows only when fetched and not the key colour
    assign fg_visible = !fg_skip && (fg_pixel != key_color);
    assign keyed      = fg_visible ? fg_pixel : bg_pixel;

    assign mix_r_wide = blend_chan({1'b0, fg_r}, {1'b0, bg_r}, opacity);
    assign mix_g      = blend_chan(fg_g, bg_g, opacity);
    assign mix_b_wide = blend_chan({1'b0, fg_b}, {1'b0, bg_b}, opacity);
    assign mix_r      = mix_r_wide[4:0];  // Top bit is always zero here
    assign mix_b      = mix_b_wide[4:0];

    assign blended = fg_skip ? bg_pixel : {mix_r, mix_g, mix_b};

    always_comb
    begin
        case (mode)
            overlay_cfg_pkg::MODE_KEY:       mixed = keyed;
            overlay_cfg_pkg::MODE_BLEND:     mixed = blended;
            overlay_cfg_pkg::MODE_KEY_BLEND: mixed = fg_visible ? blended : bg_pixel;
            default:                         mixed = bg_pixel;
        endcase
    end

    // Output register, blanked to black outside the active area
    always_ff @(posedge clk)
    begin
        if (rst)
            pixel_out <= '0;
        else
            pixel_out <= output_enable ? mixed : '0;
    end

    always_ff @(posedge clk)
    begin
        pixel_x_out <= pixel_x;
        pixel_y_out <= pixel_y;
    end

    blank_is_black: assert property (
        @(posedge clk) disable iff (rst)
        !output_enable |=> (pixel_out == '0)
    );

endmodule

`default_nettype wire

//--- logic/overlay_pipeline.sv
`default_nettype none

module overlay_pipeline (
    input  wire                             clk,
    input  wire                             rst,
    // Host register port
    input  wire                             cfg_req,
    input  wire overlay_cfg_pkg::cfg_addr_t cfg_addr,
    input  wire overlay_cfg_pkg::cfg_data_t cfg_data,
    output logic                            cfg_ack,
    // Background stream, one pixel per clock
    input  wire video_pkg::coord_t          pixel_x,
    input  wire video_pkg::coord_t          pixel_y,
    input  wire video_pkg::pixel_t          bg_pixel,
    input  wire                             output_enable,
    // Foreground memory
    output video_pkg::scoord_t              fg_req_x,
    output video_pkg::scoord_t              fg_req_y,
    output logic                            fg_req_active,
    input  wire video_pkg::pixel_t          fg_pixel,
    input  wire                             fg_skip,
    // Composited output
    output video_pkg::pixel_t               pixel_out,
    output video_pkg::coord_t               pixel_x_out,
    output video_pkg::coord_t               pixel_y_out
);
    localparam int DLY = overlay_cfg_pkg::FETCH_LATENCY;

    overlay_cfg_pkg::overlay_mode_t mode;
    overlay_cfg_pkg::fg_scale_t     scale;
    video_pkg::scoord_t             offset_x;
    video_pkg::scoord_t             offset_y;
    overlay_cfg_pkg::opacity_t      opacity;
    video_pkg::coord_t              clip_left;
    video_pkg::coord_t              clip_right;
    video_pkg::coord_t              clip_top;
    video_pkg::coord_t              clip_bottom;
    video_pkg::pixel_t              key_color;

    // Background side waits here while the foreground fetch is in flight
    video_pkg::pixel_t bg_dly [DLY];
    video_pkg::coord_t x_dly  [DLY];
    video_pkg::coord_t y_dly  [DLY];
    logic [DLY-1:0]    oe_dly;

    overlay_cfg_port i_cfg_port (
        .clk         (clk),
        .rst         (rst),
        .cfg_req     (cfg_req),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .cfg_ack     (cfg_ack),
        .mode        (mode),
        .scale       (scale),
        .offset_x    (offset_x),
        .offset_y    (offset_y),
        .opacity     (opacity),
        .clip_left   (clip_left),
        .clip_right  (clip_right),
        .clip_top    (clip_top),
        .clip_bottom (clip_bottom),
        .key_color   (key_color)
    );

    fg_addr_gen i_addr_gen (
        .clk           (clk),
        .rst           (rst),
        .pixel_x       (pixel_x),
        .pixel_y       (pixel_y),
        .output_enable (output_enable),
        .scale         (scale),
        .offset_x      (offset_x),
        .offset_y      (offset_y),
        .clip_left     (clip_left),
        .clip_right    (clip_right),
        .clip_top      (clip_top),
        .clip_bottom   (clip_bottom),
        .fg_req_x      (fg_req_x),
        .fg_req_y      (fg_req_y),
        .fg_req_active (fg_req_active)
    );

    always_ff @(posedge clk)
    begin
        bg_dly[0] <= bg_pixel;
        x_dly[0]  <= pixel_x;
        y_dly[0]  <= pixel_y;
        for (int i = 1; i < DLY; i++)
        begin
            bg_dly[i] <= bg_dly[i-1];
            x_dly[i]  <= x_dly[i-1];
            y_dly[i]  <= y_dly[i-1];
        end
    end

    // Enable starts low so nothing shows before real pixels arrive
    always_ff @(posedge clk)
    begin
        if (rst)
            oe_dly <= '0;
        else
            oe_dly <= {oe_dly[DLY-2:0], output_enable};
    end

    pixel_compositor i_compositor (
        .clk           (clk),
        .rst           (rst),
        .bg_pixel      (bg_dly[DLY-1]),
        .fg_pixel      (fg_pixel),
        .fg_skip       (fg_skip),
        .pixel_x       (x_dly[DLY-1]),
        .pixel_y       (y_dly[DLY-1]),
        .output_enable (oe_dly[DLY-1]),
        .mode          (mode),
        .opacity       (opacity),
        .key_color     (key_color),
        .pixel_out     (pixel_out),
        .pixel_x_out   (pixel_x_out),
        .pixel_y_out   (pixel_y_out)
    );

    // Coordinates leave exactly OUT_LATENCY cycles after they enter
    coord_alignment: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown($past(pixel_x, overlay_cfg_pkg::OUT_LATENCY)) |->
            pixel_x_out == $past(pixel_x, overlay_cfg_pkg::OUT_LATENCY)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset is seen by three rising edges, then released
    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_overlay_pipeline.sv
`default_nettype none

module tb_overlay_pipeline;
    localparam int NUM_RUNS    = 40;
    localparam int ACK_TIMEOUT = 20;
    localparam int RST_TIMEOUT = 20;
    localparam int IMG_SIZE    = video_pkg::FG_WIDTH * video_pkg::FG_HEIGHT;

    logic                           clk;
    logic                           rst;
    logic                           cfg_req;
    overlay_cfg_pkg::cfg_addr_t     cfg_addr;
    overlay_cfg_pkg::cfg_data_t     cfg_data;
    logic                           cfg_ack;
    video_pkg::coord_t              pixel_x;
    video_pkg::coord_t              pixel_y;
    video_pkg::pixel_t              bg_pixel;
    logic                           output_enable;
    video_pkg::scoord_t             fg_req_x;
    video_pkg::scoord_t             fg_req_y;
    logic                           fg_req_active;
    video_pkg::pixel_t              fg_pixel;
    logic                           fg_skip;
    video_pkg::pixel_t              pixel_out;
    video_pkg::coord_t              pixel_x_out;
    video_pkg::coord_t              pixel_y_out;

    // Model of the stored settings
    overlay_cfg_pkg::overlay_mode_t m_mode;
    int                             m_scale;
    int                             m_off_x;
    int                             m_off_y;
    int                             m_opacity;
    int                             m_clip_l;
    int                             m_clip_r;
    int                             m_clip_t;
    int                             m_clip_b;
    video_pkg::pixel_t              m_key;

    logic [31:0]        lcg_state;
    int                 cyc;
    video_pkg::pixel_t  fg_img [IMG_SIZE];
    video_pkg::pixel_t  mem_pix [2];   // Two-stage reply pipe of the memory model
    logic               mem_skip [2];

    // Expected results, indexed by issue cycle modulo 8
    logic               exp_valid [8];
    logic               exp_oe [8];
    logic               exp_act [8];
    video_pkg::scoord_t exp_rx [8];
    video_pkg::scoord_t exp_ry [8];
    video_pkg::pixel_t  exp_out [8];
    video_pkg::coord_t  exp_x [8];
    video_pkg::coord_t  exp_y [8];

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    overlay_pipeline i_dut (
        .clk           (clk),
        .rst           (rst),
        .cfg_req       (cfg_req),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .cfg_ack       (cfg_ack),
        .pixel_x       (pixel_x),
        .pixel_y       (pixel_y),
        .bg_pixel      (bg_pixel),
        .output_enable (output_enable),
        .fg_req_x      (fg_req_x),
        .fg_req_y      (fg_req_y),
        .fg_req_active (fg_req_active),
        .fg_pixel      (fg_pixel),
        .fg_skip       (fg_skip),
        .pixel_out     (pixel_out),
        .pixel_x_out   (pixel_x_out),
        .pixel_y_out   (pixel_y_out)
    );

    function automatic logic [15:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];  // Upper bits have the longer period
    endfunction

    function automatic int wrap(input int v, input int m);
        return ((v % m) + m) % m;
    endfunction

    task automatic finish_failed();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            finish_failed();
        end
    endtask

    // Per-channel mix in eighths
    function automatic video_pkg::pixel_t blend_model(input video_pkg::pixel_t fg,
                                                      input video_pkg::pixel_t bg, input int op);
        int r;
        int g;
        int b;
        r = (int'(fg[15:11]) * op + int'(bg[15:11]) * (8 - op)) >> 3;
        g = (int'(fg[10:5]) * op + int'(bg[10:5]) * (8 - op)) >> 3;
        b = (int'(fg[4:0]) * op + int'(bg[4:0]) * (8 - op)) >> 3;
        return {r[4:0], g[5:0], b[4:0]};
    endfunction

    function automatic video_pkg::pixel_t compose(input video_pkg::pixel_t bg,
                                                  input video_pkg::pixel_t fg, input logic act);
        logic              visible;
        video_pkg::pixel_t mix;
        visible = act && (fg != m_key);
        mix     = act ? blend_model(fg, bg, m_opacity) : bg;
        case (m_mode)
            overlay_cfg_pkg::MODE_KEY:       return visible ? fg : bg;
            overlay_cfg_pkg::MODE_BLEND:     return mix;
            overlay_cfg_pkg::MODE_KEY_BLEND: return visible ? mix : bg;
            default:                         return bg;
        endcase
    endfunction

    // One clock of the stream: memory reply, checks, then the next pixel
    task automatic cycle(input int x, input int y, input video_pkg::pixel_t bg, input logic oe);
        int                slot;
        int                fx;
        int                fy;
        logic              act;
        video_pkg::pixel_t fg;
        @(negedge clk);
        fg_pixel    = mem_pix[1];
        fg_skip     = mem_skip[1];
        mem_pix[1]  = mem_pix[0];
        mem_skip[1] = mem_skip[0];
        mem_skip[0] = !fg_req_active;
        if (fg_req_active)
            mem_pix[0] = fg_img[{fg_req_y[6:0], fg_req_x[7:0]}];
        else
            mem_pix[0] = rand_next();  // Junk the DUT must ignore

        slot = (cyc + 8 - overlay_cfg_pkg::ADDR_LATENCY) % 8;
        if (exp_valid[slot])
        begin
            check_equal(fg_req_active, exp_act[slot], "fg_req_active");
            if (exp_oe[slot])
            begin
                check_equal(fg_req_x, exp_rx[slot], "fg_req_x");
                check_equal(fg_req_y, exp_ry[slot], "fg_req_y");
            end
        end
        slot = (cyc + 8 - overlay_cfg_pkg::OUT_LATENCY) % 8;
        if (exp_valid[slot])
        begin
            check_equal(pixel_out, exp_out[slot], "pixel_out");
            check_equal(pixel_x_out, exp_x[slot], "pixel_x_out");
            check_equal(pixel_y_out, exp_y[slot], "pixel_y_out");
        end

        fx  = (x - m_off_x) >>> m_scale;
        fy  = (y - m_off_y) >>> m_scale;
        act = oe && fx >= 0 && fx < video_pkg::FG_WIDTH && fy >= 0 && fy < video_pkg::FG_HEIGHT
              && x >= m_clip_l && x < m_clip_r && y >= m_clip_t && y < m_clip_b;
        fg  = act ? fg_img[fy * video_pkg::FG_WIDTH + fx] : 16'h0;
        slot = cyc % 8;
        exp_valid[slot] = 1'b1;
        exp_oe[slot]    = oe;
        exp_act[slot]   = act;
        exp_rx[slot]    = video_pkg::scoord_t'(fx);
        exp_ry[slot]    = video_pkg::scoord_t'(fy);
        exp_out[slot]   = oe ? compose(bg, fg, act) : 16'h0;
        exp_x[slot]     = video_pkg::coord_t'(x);
        exp_y[slot]     = video_pkg::coord_t'(y);
        pixel_x       = video_pkg::coord_t'(x);
        pixel_y       = video_pkg::coord_t'(y);
        bg_pixel      = bg;
        output_enable = oe;
        cyc++;
    endtask

    task automatic idle_cycle();
        cycle(rand_next() % video_pkg::RES_X, rand_next() % video_pkg::RES_Y, rand_next(), 1'b0);
    endtask

    task automatic write_reg(input overlay_cfg_pkg::cfg_addr_t addr,
                             input overlay_cfg_pkg::cfg_data_t data);
        int waited;
        idle_cycle();
        check_equal(cfg_ack, 1'b0, "cfg_ack before request");
        cfg_addr = addr;
        cfg_data = data;
        cfg_req  = 1'b1;
        waited   = 0;
        do
        begin
            idle_cycle();
            waited++;
        end
        while (!cfg_ack && waited < ACK_TIMEOUT);
        if (!cfg_ack)
        begin
            $display("Timeout at %0t: the acknowledge never came for a register write", $time);
            finish_failed();
        end
        cfg_req = 1'b0;
        waited  = 0;
        do
        begin
            idle_cycle();
            waited++;
        end
        while (cfg_ack && waited < ACK_TIMEOUT);
        if (cfg_ack)
        begin
            $display("Timeout at %0t: the acknowledge never dropped after the request fell", $time);
            finish_failed();
        end
    endtask

    task automatic force_key_pixels(input video_pkg::pixel_t key);
        for (int i = 0; i < IMG_SIZE; i++)
        begin
            if (rand_next() % 4 == 0)
                fg_img[i] = key;
        end
    endtask

    task automatic configure();
        int op_raw;
        repeat (overlay_cfg_pkg::OUT_LATENCY) idle_cycle();  // Pixels in flight leave first
        m_mode  = overlay_cfg_pkg::overlay_mode_t'(rand_next() % 4);
        m_scale = rand_next() % 4;
        m_off_x = int'(rand_next() % 1100) - 300;  // Keeps pixel minus offset inside 12 bits
        m_off_y = int'(rand_next() % 1100) - 300;
        op_raw  = (rand_next() % 4 == 0) ? ((rand_next() % 2) ? 0 : 8) : rand_next() % 16;
        m_opacity = (op_raw > 8) ? 8 : op_raw;
        if (rand_next() % 4 == 0)
        begin
            m_clip_l = 0;
            m_clip_r = video_pkg::RES_X;
            m_clip_t = 0;
            m_clip_b = video_pkg::RES_Y;
        end
        else
        begin
            m_clip_l = rand_next() % 500;
            m_clip_r = m_clip_l + rand_next() % 700;
            m_clip_t = rand_next() % 400;
            m_clip_b = m_clip_t + rand_next() % 500;
        end
        m_key = rand_next();
        write_reg(overlay_cfg_pkg::REG_MODE, 16'(m_mode));
        write_reg(overlay_cfg_pkg::REG_SCALE, 16'(m_scale));
        write_reg(overlay_cfg_pkg::REG_OFFSET_X, 16'(m_off_x));
        write_reg(overlay_cfg_pkg::REG_OFFSET_Y, 16'(m_off_y));
        write_reg(overlay_cfg_pkg::REG_OPACITY, 16'(op_raw));
        write_reg(overlay_cfg_pkg::REG_CLIP_LEFT, 16'(m_clip_l));
        write_reg(overlay_cfg_pkg::REG_CLIP_RIGHT, 16'(m_clip_r));
        write_reg(overlay_cfg_pkg::REG_CLIP_TOP, 16'(m_clip_t));
        write_reg(overlay_cfg_pkg::REG_CLIP_BOTTOM, 16'(m_clip_b));
        write_reg(overlay_cfg_pkg::REG_KEY_COLOR, m_key);
        if (rand_next() % 3 == 0)
            write_reg(4'(10 + rand_next() % 6), rand_next());  // Unknown index, must be ignored
        force_key_pixels(m_key);
    endtask

    task automatic pixel_run(input logic with_blanks);
        int   x;
        int   y;
        int   len;
        int   blank_left;
        logic oe;
        if (rand_next() % 2)
        begin
            // Start near the foreground origin so the image is hit
            x = wrap(m_off_x + rand_next() % 128, video_pkg::RES_X);
            y = wrap(m_off_y + rand_next() % (128 << m_scale), video_pkg::RES_Y);
        end
        else
        begin
            x = rand_next() % video_pkg::RES_X;
            y = rand_next() % video_pkg::RES_Y;
        end
        len        = 32 + rand_next() % 64;
        blank_left = 0;
        repeat (len)
        begin
            if (with_blanks && blank_left == 0 && rand_next() % 8 == 0)
                blank_left = 1 + rand_next() % 6;
            oe = (blank_left == 0);
            if (blank_left > 0)
                blank_left--;
            cycle(x, y, rand_next(), oe);
            x++;
            if (x == video_pkg::RES_X)
            begin
                x = 0;
                y = (y + 1) % video_pkg::RES_Y;
            end
        end
    endtask

    initial
    begin
        int waited;
        lcg_state     = 32'd46;
        cfg_req       = 1'b0;
        cfg_addr      = '0;
        cfg_data      = '0;
        pixel_x       = '0;
        pixel_y       = '0;
        bg_pixel      = '0;
        output_enable = 1'b0;
        fg_pixel      = '0;
        fg_skip       = 1'b1;
        cyc           = 0;
        for (int i = 0; i < 2; i++)
        begin
            mem_pix[i]  = '0;
            mem_skip[i] = 1'b1;
        end
        for (int i = 0; i < 8; i++)
            exp_valid[i] = 1'b0;
        for (int i = 0; i < IMG_SIZE; i++)
            fg_img[i] = rand_next();

        // Reset values of the settings
        m_mode    = overlay_cfg_pkg::MODE_BG;
        m_scale   = 0;
        m_off_x   = 0;
        m_off_y   = 0;
        m_opacity = 8;
        m_clip_l  = 0;
        m_clip_r  = video_pkg::RES_X;
        m_clip_t  = 0;
        m_clip_b  = video_pkg::RES_Y;
        m_key     = '0;

        waited = 0;
        @(negedge clk);
        while (rst && waited < RST_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (rst)
        begin
            $display("Timeout at %0t: reset was never released", $time);
            finish_failed();
        end
        check_equal(cfg_ack, 1'b0, "cfg_ack after reset");
        check_equal(fg_req_active, 1'b0, "fg_req_active after reset");
        check_equal(pixel_out, 16'h0, "pixel_out after reset");

        pixel_run(1'b0);  // Default settings pass the background through
        for (int run = 0; run < NUM_RUNS; run++)
        begin
            configure();
            pixel_run(rand_next() % 3 == 0);
        end
        repeat (overlay_cfg_pkg::OUT_LATENCY + 2) idle_cycle();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- overlay_pipeline.f
logic/video_pkg.sv
logic/overlay_cfg_pkg.sv
logic/overlay_cfg_port.sv
logic/fg_addr_gen.sv
logic/pixel_compositor.sv
logic/overlay_pipeline.sv
testbench/tb_clock_gen.sv
testbench/tb_overlay_pipeline.sv

//--- Bender.yml
package:
  name: overlay_pipeline

sources:
  - files:
      - logic/video_pkg.sv
      - logic/overlay_cfg_pkg.sv
      - logic/overlay_cfg_port.sv
      - logic/fg_addr_gen.sv
      - logic/pixel_compositor.sv
      - logic/overlay_pipeline.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_overlay_pipeline.sv
